//--- filelist.f
+incdir+tests
logic/av_pkg.sv
logic/video_timing.sv
logic/test_pattern.sv
logic/i2s_serializer.sv
logic/av_core_top.sv
tests/tb_av_core_top.sv

//--- tests/tb_audio_vectors.svh
////////////////////
// audio sample table
// left/right pairs for the i2s checks, fixed patterns first, random rows after
////////////////////

`ifndef TB_AUDIO_VECTORS_SVH
`define TB_AUDIO_VECTORS_SVH

localparam int NUM_AUDIO_ROWS = 12;
localparam int NUM_FIXED_ROWS = 5;

// columns: left sample, right sample
// all ones, alternating bits both ways, zero, lone msb against lone lsb
localparam logic [15:0] FIXED_LEFT [NUM_FIXED_ROWS] =
    '{16'hffff, 16'haaaa, 16'h5555, 16'h0000, 16'h8000};
localparam logic [15:0] FIXED_RIGHT [NUM_FIXED_ROWS] =
    '{16'hffff, 16'h5555, 16'haaaa, 16'h0000, 16'h0001};

logic [15:0] row_left  [NUM_AUDIO_ROWS];
logic [15:0] row_right [NUM_AUDIO_ROWS];

// remaining rows drawn from the seeded generator
task automatic load_audio_table();
    int i;
    for (i = 0; i < NUM_AUDIO_ROWS; i++) begin
        if (i < NUM_FIXED_ROWS) begin
            row_left[i]  = FIXED_LEFT[i];
            row_right[i] = FIXED_RIGHT[i];
        end else begin
            row_left[i]  = 16'($urandom);
            row_right[i] = 16'($urandom);
        end
    end
endtask

`endif

//--- tests/tb_av_core_top.sv
`timescale 1ns/1ps

////////////////////
// av core testbench
// raster, test pattern and i2s output against a cycle model
////////////////////

module tb_av_core_top;

    localparam int H_TOTAL        = 400;
    localparam int V_TOTAL        = 512;
    localparam int H_ACTIVE       = 320;
    localparam int V_ACTIVE       = 240;
    localparam int H_BPORCH       = 10;
    localparam int V_BPORCH       = 10;
    localparam int HS_COLUMN      = 3;
    localparam int SQUARE         = 10;
    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    localparam int NUM_FRAMES     = 3;
    // three frames plus margin for reset and the audio table
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_CYCLES + 85600;

    logic        audgen_mclk;
    logic        reset_n;
    logic [15:0] audio_left;
    logic [15:0] audio_right;
    logic [23:0] video_rgb;
    logic        video_de;
    logic        video_vs;
    logic        video_hs;
    logic        audio_sclk;
    logic        audio_lrck;
    logic        audio_dac;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;

    `include "tb_audio_vectors.svh"

    av_core_top DUT (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .audio_left  (audio_left),
        .audio_right (audio_right),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_vs    (video_vs),
        .video_hs    (video_hs),
        .audio_sclk  (audio_sclk),
        .audio_lrck  (audio_lrck),
        .audio_dac   (audio_dac)
    );

    initial begin
        audgen_mclk = 1'b0;
        forever #4 audgen_mclk = ~audgen_mclk;
    end

    always @(posedge audgen_mclk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count == TIMEOUT_CYCLES);
        $display("timeout, run stopped after %0d cycles", cycle_count);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic flag_mismatch(input string name, input logic [31:0] expv,
                                 input logic [31:0] gotv);
        $display("MISMATCH %s expected %h got %h at %0t", name, expv, gotv, $time);
        error_count++;
    endtask

    task automatic note_failure(input string what);
        $display("%s at %0t", what, $time);
        error_count++;
    endtask

    ////////////////////
    // video model
    ////////////////////

    // one pass per cycle from the first video_vs, t counts cycles since video_vs
    task automatic check_video_frames();
        int t;
        int frame;
        int px;
        int py;
        int sq_x;
        int sq_y;
        int de_count;
        int black_count;
        logic exp_de;
        logic exp_hs;
        logic [23:0] exp_rgb;
        t = 0;
        frame = 0;
        sq_x = 135;
        sq_y = 95;
        de_count = 0;
        black_count = 0;
        while (frame < NUM_FRAMES) begin
            @(negedge audgen_mclk);
            t++;
            if (t == FRAME_CYCLES) begin
                if (!video_vs) note_failure("video_vs missing at the end of a frame");
                if (de_count != H_ACTIVE * V_ACTIVE) flag_mismatch("video_de count",
                    H_ACTIVE * V_ACTIVE, de_count);
                if (black_count != SQUARE * SQUARE) flag_mismatch("black pixel count",
                    SQUARE * SQUARE, black_count);
                // diagonal step, each axis wraps on its own
                sq_x = (sq_x == H_ACTIVE - SQUARE) ? 0 : sq_x + 1;
                sq_y = (sq_y == V_ACTIVE - SQUARE) ? 0 : sq_y + 1;
                frame++;
                t = 0;
                de_count = 0;
                black_count = 0;
            end else if (video_vs) begin
                flag_mismatch("video_vs", 0, 1);
            end
            // pixel outputs trail the raster by one cycle
            px = (t + FRAME_CYCLES - 1) % H_TOTAL - H_BPORCH;
            py = ((t + FRAME_CYCLES - 1) % FRAME_CYCLES) / H_TOTAL - V_BPORCH;
            exp_de = (px >= 0) && (px < H_ACTIVE) && (py >= 0) && (py < V_ACTIVE);
            exp_rgb = exp_de ? 24'h3c3c3c : 24'h0;
            if ((px >= sq_x) && (px < sq_x + SQUARE) && (py >= sq_y) && (py < sq_y + SQUARE))
                exp_rgb = 24'h0;
            exp_hs = (t % H_TOTAL == HS_COLUMN);
            check_count++;
            if (video_de !== exp_de) flag_mismatch("video_de", exp_de, video_de);
            if (video_rgb !== exp_rgb) flag_mismatch("video_rgb", exp_rgb, video_rgb);
            if (exp_hs && !video_hs) note_failure("video_hs missing on a line");
            if (!exp_hs && video_hs) flag_mismatch("video_hs", 0, 1);
            // audio phase reads 1 on the first video_vs, sclk div 4, lrck every 128
            if (audio_sclk !== ((t + 1) % 4 >= 2))
                flag_mismatch("audio_sclk", (t + 1) % 4 >= 2, audio_sclk);
            if (audio_lrck !== ((t + 1) % 256 >= 128))
                flag_mismatch("audio_lrck", (t + 1) % 256 >= 128, audio_lrck);
            if (video_de) de_count++;
            if (video_de && video_rgb == 24'h0) black_count++;
        end
    endtask

    ////////////////////
    // audio data
    ////////////////////

    // returns on the cycle in which audio_sclk has just gone high
    task automatic wait_sclk_rise();
        logic last;
        last = audio_sclk;
        @(negedge audgen_mclk);
        while (!(audio_sclk && !last)) begin
            last = audio_sclk;
            @(negedge audgen_mclk);
        end
    endtask

    // row f applied during audio frame f, sent in frame f + 1
    task automatic check_audio_frames();
        int frame;
        int b;
        int k;
        logic [15:0] exp_left;
        logic [15:0] exp_right;
        logic exp_bit;
        // first frame after reset carries zeros
        exp_left = '0;
        exp_right = '0;
        for (frame = 0; frame <= NUM_AUDIO_ROWS; frame++) begin
            for (b = 0; b < 64; b++) begin
                wait_sclk_rise();
                k = b % 32;
                if (k >= 16) exp_bit = 1'b0;
                else if (b < 32) exp_bit = exp_left[15 - k];
                else exp_bit = exp_right[15 - k];
                check_count++;
                if (audio_dac !== exp_bit) flag_mismatch("audio_dac", exp_bit, audio_dac);
                if (b == 0 && frame < NUM_AUDIO_ROWS) begin
                    @(posedge audgen_mclk);
                    audio_left  <= row_left[frame];
                    audio_right <= row_right[frame];
                    @(negedge audgen_mclk);
                end
            end
            if (frame < NUM_AUDIO_ROWS) begin
                exp_left  = row_left[frame];
                exp_right = row_right[frame];
            end
        end
    endtask

    initial begin
        logic [29:0] outs;
        void'($urandom(22));
        load_audio_table();
        reset_n     = 1'b0;
        audio_left  = '0;
        audio_right = '0;
        // everything silent while reset is held
        repeat (5) begin
            @(negedge audgen_mclk);
            outs = {video_vs, video_hs, video_de, video_rgb, audio_sclk, audio_lrck, audio_dac};
            check_count++;
            if (outs !== '0) flag_mismatch("video_vs,hs,de,rgb audio_sclk,lrck,dac", 0, outs);
        end
        @(posedge audgen_mclk);
        reset_n <= 1'b1;
        repeat (2) @(negedge audgen_mclk);
        check_count++;
        if (video_vs !== 1'b1) note_failure("video_vs did not rise on the first cycle after reset");
        fork
            check_video_frames();
            check_audio_frames();
        join
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- logic/av_core_top.sv
`timescale 1ns/1ps

////////////////////
// av core top
// raster timing, test pattern and i2s output on the audio master clock
////////////////////

module av_core_top import av_pkg::*; #(
    parameter coord_t H_TOTAL  = H_TOTAL_DEF,
    parameter coord_t H_ACTIVE = H_ACTIVE_DEF,
    parameter coord_t H_BPORCH = H_BPORCH_DEF,
    parameter coord_t V_TOTAL  = V_TOTAL_DEF,
    parameter coord_t V_ACTIVE = V_ACTIVE_DEF,
    parameter coord_t V_BPORCH = V_BPORCH_DEF
) (
    input  logic          audgen_mclk,
    input  logic          reset_n,
    input  audio_sample_t audio_left,
    input  audio_sample_t audio_right,
    output rgb_t          video_rgb,
    output logic          video_de,
    output logic          video_vs,
    output logic          video_hs,
    output logic          audio_sclk,
    output logic          audio_lrck,
    output logic          audio_dac
);

    // raster position from timing to pattern
    coord_t x_count;
    coord_t y_count;
    logic   active;
    logic   frame_end;

    ////////////////////
    // video
    ////////////////////

    video_timing #(
        .H_TOTAL  (H_TOTAL),
        .H_ACTIVE (H_ACTIVE),
        .H_BPORCH (H_BPORCH),
        .V_TOTAL  (V_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_BPORCH (V_BPORCH)
    ) u_video_timing (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .x_count     (x_count),
        .y_count     (y_count),
        .active      (active),
        .frame_end   (frame_end),
        .video_vs    (video_vs),
        .video_hs    (video_hs)
    );

    test_pattern #(
        .H_TOTAL  (H_TOTAL),
        .H_ACTIVE (H_ACTIVE),
        .H_BPORCH (H_BPORCH),
        .V_TOTAL  (V_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_BPORCH (V_BPORCH)
    ) u_test_pattern (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .x_count     (x_count),
        .y_count     (y_count),
        .active      (active),
        .frame_end   (frame_end),
        .video_rgb   (video_rgb),
        .video_de    (video_de)
    );

    ////////////////////
    // audio
    ////////////////////

    // 48 kHz frames, mclk / 4 bit clock
    i2s_serializer u_i2s_serializer (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .audio_left  (audio_left),
        .audio_right (audio_right),
        .audio_sclk  (audio_sclk),
        .audio_lrck  (audio_lrck),
        .audio_dac   (audio_dac)
    );

endmodule

//--- logic/i2s_serializer.sv
`timescale 1ns/1ps

////////////////////
// i2s serializer
// bit clock and word select from a free running phase counter,
// 16-bit samples msb first then zero padding per channel
////////////////////

module i2s_serializer import av_pkg::*; (
    input  logic          audgen_mclk,
    input  logic          reset_n,
    input  audio_sample_t audio_left,
    input  audio_sample_t audio_right,
    output logic          audio_sclk,
    output logic          audio_lrck,
    output logic          audio_dac
);

    // phase bits: divider, then bit index, then channel
    localparam int DIV_W      = $clog2(SCLK_DIV);
    localparam int FRAME_BITS = 2 * BITS_PER_CHANNEL;
    localparam int PHASE_W    = $clog2(SCLK_DIV * FRAME_BITS);
    localparam int PAD_BITS   = BITS_PER_CHANNEL - SAMPLE_BITS;

    logic [PHASE_W-1:0]    phase;
    logic [FRAME_BITS-1:0] shift_reg;
    logic                  frame_wrap;
    logic                  bit_end;

    // last mclk of the audio frame and of each bit
    assign frame_wrap = (phase == '1);
    assign bit_end    = (phase[DIV_W-1:0] == DIV_W'(SCLK_DIV - 1));

    ////////////////////
    // phase counter
    ////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // sclk low for the first half of each bit, lrck high for right
    assign audio_sclk = phase[DIV_W-1];
    assign audio_lrck = phase[PHASE_W-1];

    ////////////////////
    // sample shifter
    ////////////////////

    // whole frame loaded at the wrap, zeros go out until then
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            shift_reg <= '0;
        end else if (frame_wrap) begin
            shift_reg <= {audio_left, {PAD_BITS{1'b0}}, audio_right, {PAD_BITS{1'b0}}};
        end else if (bit_end) begin
            shift_reg <= {shift_reg[FRAME_BITS-2:0], 1'b0};
        end
    end

    assign audio_dac = shift_reg[FRAME_BITS-1];

    a_lrck_sclk_low: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        $changed(audio_lrck) |-> !audio_sclk);
    // padding half of each channel stays silent
    a_pad_zero: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        (phase[PHASE_W-2:DIV_W] >= SAMPLE_BITS) |-> !audio_dac);

endmodule

//--- logic/test_pattern.sv
`timescale 1ns/1ps

////////////////////
// test pattern generator
// gray field with a black square stepping one pixel diagonally per frame
////////////////////

module test_pattern import av_pkg::*; #(
    parameter coord_t H_TOTAL  = H_TOTAL_DEF,
    parameter coord_t H_ACTIVE = H_ACTIVE_DEF,
    parameter coord_t H_BPORCH = H_BPORCH_DEF,
    parameter coord_t V_TOTAL  = V_TOTAL_DEF,
    parameter coord_t V_ACTIVE = V_ACTIVE_DEF,
    parameter coord_t V_BPORCH = V_BPORCH_DEF
) (
    input  logic   audgen_mclk,
    input  logic   reset_n,
    input  coord_t x_count,
    input  coord_t y_count,
    input  logic   active,
    input  logic   frame_end,
    output rgb_t   video_rgb,
    output logic   video_de
);

    coord_t visible_x;
    coord_t visible_y;
    coord_t square_x;
    coord_t square_y;
    logic   in_square;

    // screen coordinates, only meaningful inside the active window
    assign visible_x = x_count - H_BPORCH;
    assign visible_y = y_count - V_BPORCH;

    assign in_square = (visible_x >= square_x) && (visible_x < square_x + SQUARE_SIZE) &&
                       (visible_y >= square_y) && (visible_y < square_y + SQUARE_SIZE);

    ////////////////////
    // square position
    ////////////////////

    // steps once per frame, each axis wraps on its own
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            square_x <= SQUARE_X_INIT;
            square_y <= SQUARE_Y_INIT;
        end else if (frame_end) begin
            if (square_x == H_ACTIVE - SQUARE_SIZE) begin
                square_x <= '0;
            end else begin
                square_x <= square_x + 1'b1;
            end
            if (square_y == V_ACTIVE - SQUARE_SIZE) begin
                square_y <= '0;
            end else begin
                square_y <= square_y + 1'b1;
            end
        end
    end

    ////////////////////
    // pixel output
    ////////////////////

    // one cycle behind the counters
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            video_de  <= 1'b0;
            video_rgb <= '0;
        end else begin
            video_de <= active;
            // blanking and square are black
            if (active && !in_square) begin
                video_rgb <= {BG_LEVEL, BG_LEVEL, BG_LEVEL};
            end else begin
                video_rgb <= '0;
            end
        end
    end

    a_blank_black: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        !video_de |-> (video_rgb == '0));

endmodule

//--- logic/video_timing.sv
`timescale 1ns/1ps

////////////////////
// video raster timing
// column and line counters, single-cycle frame and line strobes
// and the visible window flag
////////////////////

module video_timing import av_pkg::*; #(
    parameter coord_t H_TOTAL  = H_TOTAL_DEF,
    parameter coord_t H_ACTIVE = H_ACTIVE_DEF,
    parameter coord_t H_BPORCH = H_BPORCH_DEF,
    parameter coord_t V_TOTAL  = V_TOTAL_DEF,
    parameter coord_t V_ACTIVE = V_ACTIVE_DEF,
    parameter coord_t V_BPORCH = V_BPORCH_DEF
) (
    input  logic   audgen_mclk,
    input  logic   reset_n,
    output coord_t x_count,
    output coord_t y_count,
    output logic   active,
    output logic   frame_end,
    output logic   video_vs,
    output logic   video_hs
);

    // low for the first cycle after reset, raster holds at (0,0)
    logic   running;
    coord_t x_next;
    coord_t y_next;

    ////////////////////
    // next raster position
    ////////////////////

    always_comb begin
        x_next = x_count;
        y_next = y_count;
        if (running) begin
            if (x_count == H_TOTAL - 1'b1) begin
                x_next = '0;
                // last column, step the line
                if (y_count == V_TOTAL - 1'b1) begin
                    y_next = '0;
                end else begin
                    y_next = y_count + 1'b1;
                end
            end else begin
                x_next = x_count + 1'b1;
            end
        end
    end

    ////////////////////
    // counters and strobes
    ////////////////////

    // flags decoded from the next position so they line up with the counters
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            running   <= 1'b0;
            x_count   <= '0;
            y_count   <= '0;
            active    <= 1'b0;
            frame_end <= 1'b0;
            video_vs  <= 1'b0;
            video_hs  <= 1'b0;
        end else begin
            running   <= 1'b1;
            x_count   <= x_next;
            y_count   <= y_next;
            // new frame at the raster origin
            video_vs  <= (x_next == '0) && (y_next == '0);
            // new line, kept clear of the frame strobe
            video_hs  <= (x_next == HS_COLUMN);
            active    <= (x_next >= H_BPORCH) && (x_next < H_BPORCH + H_ACTIVE) &&
                         (y_next >= V_BPORCH) && (y_next < V_BPORCH + V_ACTIVE);
            frame_end <= (x_next == H_TOTAL - 1'b1) && (y_next == V_TOTAL - 1'b1);
        end
    end

    // strobes never stretch past one cycle
    a_vs_single: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        video_vs |=> !video_vs);
    a_hs_single: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        video_hs |=> !video_hs);
    a_x_range: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        x_count < H_TOTAL);

endmodule

//--- logic/av_pkg.sv
////////////////////
// av core shared definitions
// pixel and coordinate types, raster defaults, pattern and i2s constants
////////////////////

package av_pkg;

    ////////////////////
    // types
    ////////////////////

    // raster or screen coordinate
    typedef logic [9:0] coord_t;

    // 8 bits each, red in the top byte
    typedef logic [23:0] rgb_t;

    // one pcm channel sample
    typedef logic signed [15:0] audio_sample_t;

    ////////////////////
    // raster defaults
    ////////////////////

    // 400 x 512 total gives 204800 clocks per frame at 12.288 MHz
    localparam coord_t H_TOTAL_DEF  = 10'd400;
    localparam coord_t H_ACTIVE_DEF = 10'd320;
    localparam coord_t H_BPORCH_DEF = 10'd10;
    localparam coord_t V_TOTAL_DEF  = 10'd512;
    localparam coord_t V_ACTIVE_DEF = 10'd240;
    localparam coord_t V_BPORCH_DEF = 10'd10;

    // line strobe a few columns after the frame strobe
    localparam coord_t HS_COLUMN    = 10'd3;

    ////////////////////
    // test pattern
    ////////////////////

    localparam logic [7:0] BG_LEVEL = 8'd60;
    localparam coord_t SQUARE_SIZE   = 10'd10;
    localparam coord_t SQUARE_X_INIT = 10'd135;
    localparam coord_t SQUARE_Y_INIT = 10'd95;

    ////////////////////
    // i2s format
    ////////////////////

    // mclk cycles per bit clock
    localparam int SCLK_DIV         = 4;
    localparam int BITS_PER_CHANNEL = 32;
    localparam int SAMPLE_BITS      = 16;

endpackage
